/* filelist.f */
verilog/qos_arb_pkg.sv
verilog/max_score_finder.sv
verilog/qos_arbiter.sv
verilog/payload_mux.sv
verilog/grant_stats.sv
verilog/qos_arb_top.sv
verification/qos_arb_assertions.sv
verification/qos_arb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the QoS arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module qos_arb_tb

output=$(./obj_dir/Vqos_arb_tb 2>&1) || { printf '%s\n' "$output"; exit 1; }
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
else
    exit 1
fi

/* verification/qos_arb_assertions.sv */
// Concurrent checks on the QoS arbiter outputs; attached to the top level by bind
`timescale 1ns/10ps

module qos_arb_assertions
    import qos_arb_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input req_entry_t [NUM_REQ-1:0] req_entries_i,
    input logic [NUM_REQ-1:0]       grant_i,
    input port_out_t                port_i
);

    logic [NUM_REQ-1:0] req_vec;

    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            req_vec[i] = req_entries_i[i].req;
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_i))
        else $error("grant_o has more than one bit set: %b", grant_i);

    valid_matches_grant: assert property (@(posedge clk) disable iff (!rst_n)
        port_i.valid == (|grant_i))
        else $error("port_o.valid disagrees with grant_o");

    // Two-cycle latency from request sample to grant
    grant_had_request: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_i & ~$past(req_vec, 2)) == '0)
        else $error("grant_o %b without a request two cycles earlier", grant_i);

endmodule

bind qos_arb_top qos_arb_assertions u_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_entries_i (req_entries_i),
    .grant_i       (grant_o),
    .port_i        (port_o)
);

/* verification/qos_arb_tb.sv */
// Testbench for the QoS arbiter; runs directed and random rows against a reference model
`timescale 1ns/10ps

module qos_arb_tb
    import qos_arb_pkg::*;
();

    localparam int TBL_N         = 12;
    localparam int RAND_N        = 200;
    localparam int SAT_N         = 300;
    localparam int DRAIN_TIMEOUT = 20;

    // Per-requester fields packed side by side with requester 0 in the low bits
    typedef struct packed {
        logic [NUM_REQ-1:0]         req;
        logic [NUM_REQ*SCORE_W-1:0] score;
        logic [NUM_REQ*DATA_W-1:0]  data;
    } row_t;

    typedef struct packed {
        logic [NUM_REQ-1:0] grant;
        logic               valid;
        logic [IDX_W-1:0]   src;
        logic [DATA_W-1:0]  data;
    } expect_t;

    // Directed rows with the winner noted per row
    localparam row_t ROWS [TBL_N] = '{
        {4'b0000, 16'h0000, 64'h0000_0000_0000_0000},  // idle
        {4'b0000, 16'hffff, 64'hdead_beef_cafe_f00d},  // idle with junk on the lines
        {4'b1111, 16'h7953, 64'h0203_0202_0201_0200},  // 2
        {4'b0011, 16'h00e2, 64'h0303_0302_0301_0300},  // 1 beats index 0
        {4'b1111, 16'hf888, 64'h0403_0402_0401_0400},  // 3
        {4'b1110, 16'h6660, 64'h0503_0502_0501_0500},  // tie goes to 1
        {4'b1111, 16'haaaa, 64'h0603_0602_0601_0600},  // tie goes to 0
        {4'b0100, 16'h0000, 64'h0703_0702_0701_0700},  // lone zero score at 2
        {4'b1010, 16'h0000, 64'h0803_0802_0801_0800},  // zero-score tie goes to 1
        {4'b1001, 16'h1000, 64'h0903_0902_0901_0900},  // 3
        {4'b1100, 16'h9e00, 64'h0a03_0a02_0a01_0a00},  // 2
        {4'b0001, 16'h000c, 64'h0b03_0b02_0b01_0b00}   // 0
    };

    logic                     clk;
    logic                     rst_n;
    req_entry_t [NUM_REQ-1:0] req_entries;
    logic [IDX_W-1:0]         stat_sel;
    logic [NUM_REQ-1:0]       grant;
    port_out_t                port;
    logic [CNT_W-1:0]         stat_cnt;

    expect_t     pending [$];
    int unsigned model_cnt [NUM_REQ];
    int unsigned checks;
    int unsigned errors;
    int unsigned timeouts;
    logic [31:0] rng_state;

    qos_arb_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_entries_i (req_entries),
        .stat_sel_i    (stat_sel),
        .grant_o       (grant),
        .port_o        (port),
        .stat_cnt_o    (stat_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic row_t random_row();
        row_t        r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = next_random();
        b = next_random();
        c = next_random();
        r.req   = a[3:0];
        r.score = a[19:4];
        r.data  = {b, c};
        return r;
    endfunction

    // Reference model picks the top score first, then the lowest index holding it
    function automatic expect_t predict(input row_t r);
        expect_t            e;
        logic [SCORE_W-1:0] top;
        int                 win;
        e   = '0;
        top = '0;
        win = -1;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (r.req[i] && r.score[i*SCORE_W +: SCORE_W] > top) begin
                top = r.score[i*SCORE_W +: SCORE_W];
            end
        end
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (r.req[i] && r.score[i*SCORE_W +: SCORE_W] == top) begin
                win = i;
            end
        end
        if (win >= 0) begin
            e.valid      = 1'b1;
            e.src        = IDX_W'(win);
            e.grant[win] = 1'b1;
            e.data       = r.data[win*DATA_W +: DATA_W];
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic drive_row(input row_t r);
        for (int i = 0; i < NUM_REQ; i++) begin
            req_entries[i].req   = r.req[i];
            req_entries[i].score = r.score[i*SCORE_W +: SCORE_W];
            req_entries[i].data  = r.data[i*DATA_W +: DATA_W];
        end
    endtask

    // Check the row from two edges back, then drive the next one
    task automatic apply_row(input row_t r);
        expect_t e;
        expect_t due;
        @(negedge clk);
        due = pending.pop_front();
        check_field("grant_o", 32'(grant), 32'(due.grant));
        check_field("port_o.valid", 32'(port.valid), 32'(due.valid));
        if (due.valid) begin
            check_field("port_o.src", 32'(port.src), 32'(due.src));
            check_field("port_o.data", 32'(port.data), 32'(due.data));
        end
        drive_row(r);
        e = predict(r);
        pending.push_back(e);
        for (int i = 0; i < NUM_REQ; i++) begin
            if (e.grant[i] && model_cnt[i] < 32'(CNT_MAX)) begin
                model_cnt[i]++;
            end
        end
    endtask

    task automatic drain();
        int waited;
        repeat (2) apply_row('0);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((grant !== '0 || port.valid !== 1'b0) && waited < DRAIN_TIMEOUT);
        if (grant !== '0 || port.valid !== 1'b0) begin
            timeouts++;
            $display("Timeout: grants still active after %0d idle cycles", waited);
        end
    endtask

    task automatic read_stats();
        for (int i = 0; i < NUM_REQ; i++) begin
            stat_sel = IDX_W'(i);
            @(negedge clk);
            check_field($sformatf("stat_cnt_o[%0d]", i), 32'(stat_cnt), model_cnt[i]);
        end
    endtask

    initial begin
        row_t r;
        rst_n       = 1'b0;
        stat_sel    = '0;
        req_entries = '0;
        rng_state   = 32'h0eb4_e331;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        for (int i = 0; i < NUM_REQ; i++) begin
            model_cnt[i] = 0;
        end
        // Pipeline is empty coming out of reset
        pending.push_back('0);
        pending.push_back('0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        // Outputs hold their reset values while rst_n is low
        check_field("grant_o", 32'(grant), 32'd0);
        check_field("port_o.valid", 32'(port.valid), 32'd0);
        rst_n = 1'b1;

        for (int k = 0; k < TBL_N; k++) begin
            apply_row(ROWS[k]);
        end
        for (int k = 0; k < RAND_N; k++) begin
            apply_row(random_row());
        end
        drain();
        read_stats();

        // Requester 3 alone until its counter saturates
        for (int k = 0; k < SAT_N; k++) begin
            r     = random_row();
            r.req = 4'b1000;
            apply_row(r);
        end
        drain();
        read_stats();
        stat_sel = 2'd3;
        @(negedge clk);
        check_field("stat_cnt_o[3]", 32'(stat_cnt), 32'd255);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog/grant_stats.sv */
// Per-requester saturating grant counters with a selectable combinational read port
`timescale 1ns/10ps

module grant_stats
    import qos_arb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM_REQ-1:0] grant_i,
    input  logic [IDX_W-1:0]   stat_sel_i,
    output logic [CNT_W-1:0]   stat_cnt_o
);

    logic [CNT_W-1:0] cnt_q [NUM_REQ];
    logic [NUM_REQ-1:0] inc;

    // Count only while below the ceiling
    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            inc[i] = grant_i[i] && (cnt_q[i] != CNT_MAX);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REQ; i++) begin
                if (inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // Combinational read port
    assign stat_cnt_o = cnt_q[stat_sel_i];

endmodule

/* verilog/max_score_finder.sv */
// Combinational search for the highest-scoring request; used as stage 1 of the arbiter
`timescale 1ns/10ps

module max_score_finder
    import qos_arb_pkg::*;
(
    input  req_entry_t [NUM_REQ-1:0] entries_i,
    output arb_result_t              result_o
);

    logic               found;
    logic [IDX_W-1:0]   best_idx;
    logic [SCORE_W-1:0] best_score;

    // Scan from index 0 upward
    // Strict compare keeps the lower index on a tie
    always_comb begin
        found      = 1'b0;
        best_idx   = '0;
        best_score = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (entries_i[i].req) begin
                // First request wins outright, so score zero stays eligible
                if (!found || (entries_i[i].score > best_score)) begin
                    best_idx   = IDX_W'(i);
                    best_score = entries_i[i].score;
                end
                found = 1'b1;
            end
        end
    end

    // idx and score stay zero when nothing is requested
    always_comb begin
        result_o.any   = found;
        result_o.idx   = best_idx;
        result_o.score = best_score;
    end

endmodule

/* verilog/payload_mux.sv */
// Payload delay line and winner select; drives the shared output port next to the arbiter
`timescale 1ns/10ps

module payload_mux
    import qos_arb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  req_entry_t [NUM_REQ-1:0] entries_i,
    input  arb_result_t              result_i,
    output port_out_t                port_o
);

    logic [DATA_W-1:0] data_s1_q [NUM_REQ];
    logic [DATA_W-1:0] data_s2_q [NUM_REQ];

    // Two-deep delay so the data lines up with the stage-2 result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                data_s1_q[i] <= '0;
                data_s2_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REQ; i++) begin
                data_s1_q[i] <= entries_i[i].data;
                data_s2_q[i] <= data_s1_q[i];
            end
        end
    end

    // Winner select
    always_comb begin
        port_o.valid = result_i.any;
        port_o.src   = result_i.idx;
        port_o.data  = data_s2_q[result_i.idx];
    end

endmodule

/* verilog/qos_arb_pkg.sv */
// Shared sizes and packed structs for the QoS arbiter; imported by every RTL block
package qos_arb_pkg;

    // Requester count and index width
    localparam int NUM_REQ = 4;
    localparam int IDX_W   = 2;

    // QoS score and payload widths
    localparam int SCORE_W = 4;
    localparam int DATA_W  = 16;

    // Grant counters saturate at all ones
    localparam int CNT_W = 8;
    localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

    // One requester's input sampled every cycle
    typedef struct packed {
        logic               req;
        logic [SCORE_W-1:0] score;
        logic [DATA_W-1:0]  data;
    } req_entry_t;

    // Arbitration decision as produced by the finder and held per stage
    typedef struct packed {
        // At least one request present
        logic               any;
        logic [IDX_W-1:0]   idx;
        logic [SCORE_W-1:0] score;
    } arb_result_t;

    // Shared output port
    typedef struct packed {
        logic               valid;
        logic [IDX_W-1:0]   src;
        logic [DATA_W-1:0]  data;
    } port_out_t;

    // Empty decision used as reset value
    localparam arb_result_t ARB_IDLE = '{
        any:   1'b0,
        idx:   '0,
        score: '0
    };

endpackage

/* verilog/qos_arb_top.sv */
// Top level of the QoS arbiter subsystem; connects arbitration, payload path and statistics
`timescale 1ns/10ps

module qos_arb_top
    import qos_arb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  req_entry_t [NUM_REQ-1:0] req_entries_i,
    input  logic [IDX_W-1:0]         stat_sel_i,
    output logic [NUM_REQ-1:0]       grant_o,
    output port_out_t                port_o,
    output logic [CNT_W-1:0]         stat_cnt_o
);

    arb_result_t arb_res;

    qos_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .entries_i (req_entries_i),
        .grant_o   (grant_o),
        .result_o  (arb_res)
    );

    // Same two-cycle latency as the grant
    payload_mux u_payload (
        .clk       (clk),
        .rst_n     (rst_n),
        .entries_i (req_entries_i),
        .result_i  (arb_res),
        .port_o    (port_o)
    );

    grant_stats u_stats (
        .clk        (clk),
        .rst_n      (rst_n),
        .grant_i    (grant_o),
        .stat_sel_i (stat_sel_i),
        .stat_cnt_o (stat_cnt_o)
    );

endmodule

/* verilog/qos_arbiter.sv */
// Two-stage QoS arbitration pipeline; takes the request array and gives a registered one-hot grant
`timescale 1ns/10ps

module qos_arbiter
    import qos_arb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  req_entry_t [NUM_REQ-1:0] entries_i,
    output logic [NUM_REQ-1:0]       grant_o,
    output arb_result_t              result_o
);

    arb_result_t        find_res;
    arb_result_t        s1_q;
    arb_result_t        s2_q;
    logic [NUM_REQ-1:0] grant_d;
    logic [NUM_REQ-1:0] grant_q;

    // Winner search on the live inputs
    max_score_finder u_finder (
        .entries_i (entries_i),
        .result_o  (find_res)
    );

    // Stage 1 captures the decision at the sampling edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_q <= ARB_IDLE;
        end else begin
            s1_q <= find_res;
        end
    end

    // One-hot decode of the stage-1 winner
    always_comb begin
        grant_d = '0;
        if (s1_q.any) begin
            grant_d[s1_q.idx] = 1'b1;
        end
    end

    // Stage 2 holds grant and result together
    // Grant is a single-cycle pulse per decision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= '0;
            s2_q    <= ARB_IDLE;
        end else begin
            grant_q <= grant_d;
            s2_q    <= s1_q;
        end
    end

    assign grant_o  = grant_q;
    // Result is aligned with grant_o for the payload path
    assign result_o = s2_q;

endmodule
